// File: alu_execute.sv
`timescale 1ns/1ps

module alu_execute #(
  parameter int data_width = cpu_cfg_pkg::data_width
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   operand_valid,
  input  cpu_isa_pkg::opcode_e                   op,
  input  logic [cpu_isa_pkg::reg_addr_width-1:0] rd,
  input  logic [cpu_isa_pkg::imm_width-1:0]      imm,
  input  logic [data_width-1:0]                  rs_data,
  input  logic [data_width-1:0]                  rt_data,
  output logic                                   exec_valid,
  output logic [data_width-1:0]                  exec_result,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] exec_dst,
  output logic                                   exec_write
);

  import cpu_isa_pkg::*;

  logic [shamt_width-1:0] shamt;
  logic [data_width-1:0]  imm_ext;
  logic [data_width-1:0]  alu_out;
  logic                   alu_write;

  assign shamt   = imm[shamt_width-1:0];   // rt nibble of the instruction
  assign imm_ext = {{(data_width-imm_width){imm[imm_width-1]}}, imm};

  ////////////////////
  // operation select
  ////////////////////
  always_comb begin
    alu_write = 1'b1;
    case (op)
      op_add:  alu_out = rs_data + rt_data;   // wraps
      op_sub:  alu_out = rs_data - rt_data;
      op_and:  alu_out = rs_data & rt_data;
      op_or:   alu_out = rs_data | rt_data;
      op_xor:  alu_out = rs_data ^ rt_data;
      op_sll:  alu_out = rs_data << shamt;    // zero fill
      op_srl:  alu_out = rs_data >> shamt;
      op_lli:  alu_out = imm_ext;
      default: begin
        // unused code, behaves as a no-op
        alu_out   = '0;
        alu_write = 1'b0;
      end
    endcase
  end

  // pulse follows operand_valid by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
      exec_write <= 1'b0;
    end else begin
      exec_valid <= operand_valid;
      if (operand_valid) exec_write <= alu_write;
    end
  end

  always_ff @(posedge clk) begin
    if (operand_valid) begin
      exec_result <= alu_out;
      exec_dst    <= rd;
    end
  end

endmodule

// File: cpu_cfg_pkg.sv
package cpu_cfg_pkg;

  ////////////////////
  // datapath defaults
  ////////////////////

  // bits per register word, 32 works as well
  localparam int data_width = 16;

  // number of architectural registers, r0 reads as zero
  localparam int reg_count = 16;

endpackage

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter int data_width = cpu_cfg_pkg::data_width,
  parameter int reg_count  = cpu_cfg_pkg::reg_count
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   req,
  input  logic [cpu_isa_pkg::instr_width-1:0]    instr,
  output logic                                   ack,
  output logic [data_width-1:0]                  result_data,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] result_dst
);

  import cpu_isa_pkg::*;

  ////////////////////
  // stage wires
  ////////////////////
  logic [reg_addr_width-1:0] rs_addr;
  logic [reg_addr_width-1:0] rt_addr;
  logic [reg_addr_width-1:0] rd;
  opcode_e                   op;
  logic [imm_width-1:0]      imm;
  logic                      operand_valid;

  logic [data_width-1:0]     rs_data;
  logic [data_width-1:0]     rt_data;

  logic                      exec_valid;   // alu result pulse
  logic [data_width-1:0]     exec_result;
  logic [reg_addr_width-1:0] exec_dst;
  logic                      exec_write;

  logic                      wr_en;   // back into the regfile
  logic [reg_addr_width-1:0] wr_addr;
  logic [data_width-1:0]     wr_data;

  instr_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .instr         (instr),
    .ack           (ack),
    .rs_addr       (rs_addr),
    .rt_addr       (rt_addr),
    .rd            (rd),
    .op            (op),
    .imm           (imm),
    .operand_valid (operand_valid)
  );

  reg_file #(.data_width(data_width), .reg_count(reg_count)) u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  alu_execute #(.data_width(data_width)) u_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .operand_valid (operand_valid),
    .op            (op),
    .rd            (rd),
    .imm           (imm),
    .rs_data       (rs_data),
    .rt_data       (rt_data),
    .exec_valid    (exec_valid),
    .exec_result   (exec_result),
    .exec_dst      (exec_dst),
    .exec_write    (exec_write)
  );

  result_writeback #(.data_width(data_width)) u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .exec_valid  (exec_valid),
    .exec_result (exec_result),
    .exec_dst    (exec_dst),
    .exec_write  (exec_write),
    .req         (req),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .ack         (ack),
    .result_data (result_data),
    .result_dst  (result_dst)
  );

endmodule

// File: cpu_core_chk.sv
`timescale 1ns/1ps

module cpu_core_chk #(
  parameter int data_width = cpu_cfg_pkg::data_width
) (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic                                   req,
  input logic                                   ack,
  input logic [data_width-1:0]                  result_data,
  input logic [cpu_isa_pkg::reg_addr_width-1:0] result_dst
);

  int fail_count = 0;   // failed assertions so far

  ////////////////////
  // four phase handshake
  ////////////////////

  // req was high at the edge that raised ack
  ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else begin
      fail_count++;
      $error("ack rose while req was low");
    end

  // the fall comes one edge after req is seen low
  ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
    else begin
      fail_count++;
      $error("ack fell without req sampled low");
    end

  ////////////////////
  // result ports
  ////////////////////
  result_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && $past(ack)) |-> ($stable(result_data) && $stable(result_dst)))
    else begin
      fail_count++;
      $error("result changed while ack high");
    end

endmodule

bind cpu_core cpu_core_chk #(.data_width(data_width)) u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .ack         (ack),
  .result_data (result_data),
  .result_dst  (result_dst)
);

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

  ////////////////////
  // instruction format
  ////////////////////

  // one instruction word, four nibble fields high to low
  localparam int instr_width    = 16;
  localparam int opcode_width   = 4;
  localparam int reg_addr_width = 4;   // register index
  localparam int imm_width      = 8;   // lli immediate is the low byte
  localparam int shamt_width    = 4;   // shift amount lives in the rt nibble

  // lsb position of each field
  localparam int op_lsb = 12;
  localparam int rd_lsb = 8;
  localparam int rs_lsb = 4;
  localparam int rt_lsb = 0;

  ////////////////////
  // opcodes
  ////////////////////

  // codes 8..15 are unused, they complete the handshake but write nothing
  typedef enum logic [opcode_width-1:0] {
    op_add = 4'h0,   // rd = rs + rt
    op_sub = 4'h1,   // rd = rs - rt
    op_and = 4'h2,
    op_or  = 4'h3,
    op_xor = 4'h4,
    op_sll = 4'h5,   // rd = rs << rt field
    op_srl = 4'h6,   // logical, zero fill
    op_lli = 4'h7    // rd = sign extended low byte
  } opcode_e;

endpackage

// File: instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 req,
  input  logic [cpu_isa_pkg::instr_width-1:0]  instr,
  input  logic                                 ack,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] rs_addr,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] rt_addr,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] rd,
  output cpu_isa_pkg::opcode_e                 op,
  output logic [cpu_isa_pkg::imm_width-1:0]    imm,
  output logic                                 operand_valid
);

  import cpu_isa_pkg::*;

  typedef enum logic [1:0] {
    st_idle,   // waiting for req
    st_read,   // read addresses out, regfile sampling them
    st_wait    // result in flight or handshake closing
  } decode_state_e;

  decode_state_e            state;
  logic [instr_width-1:0]   instr_q;   // held until back in idle
  logic                     accept;

  assign accept = (state == st_idle) && req;

  ////////////////////
  // handshake fsm
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= st_idle;
      operand_valid <= 1'b0;
    end else begin
      operand_valid <= 1'b0;   // single cycle pulse
      case (state)
        st_idle: if (req) state <= st_read;
        st_read: begin
          operand_valid <= 1'b1;   // regfile outputs valid next cycle
          state         <= st_wait;
        end
        // wait for both req and ack low before taking another one
        st_wait: if (!req && !ack) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // instruction capture
  always_ff @(posedge clk) begin
    if (accept) instr_q <= instr;
  end

  ////////////////////
  // field split
  ////////////////////
  assign op      = opcode_e'(instr_q[op_lsb +: opcode_width]);
  assign rd      = instr_q[rd_lsb +: reg_addr_width];
  assign rs_addr = instr_q[rs_lsb +: reg_addr_width];
  assign rt_addr = instr_q[rt_lsb +: reg_addr_width];
  assign imm     = instr_q[imm_width-1:0];   // rt field sits in here too

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int data_width = cpu_cfg_pkg::data_width,
  parameter int reg_count  = cpu_cfg_pkg::reg_count
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [cpu_isa_pkg::reg_addr_width-1:0] rs_addr,
  input  logic [cpu_isa_pkg::reg_addr_width-1:0] rt_addr,
  output logic [data_width-1:0]                  rs_data,
  output logic [data_width-1:0]                  rt_data,
  input  logic                                   wr_en,
  input  logic [cpu_isa_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [data_width-1:0]                  wr_data
);

  import cpu_isa_pkg::*;

  // r0 index, writes to it are dropped
  localparam logic [reg_addr_width-1:0] zero_reg = '0;

  logic [data_width-1:0] regs [reg_count];
  logic                  wr_ok;

  assign wr_ok = wr_en && (wr_addr != zero_reg);

  ////////////////////
  // write port
  ////////////////////

  // whole array cleared on reset, so r0 starts and stays at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // read ports
  ////////////////////

  // sampled every edge, same edge write gives the old word
  always_ff @(posedge clk) begin
    rs_data <= regs[rs_addr];
    rt_data <= regs[rt_addr];
  end

endmodule

// File: result_writeback.sv
`timescale 1ns/1ps

module result_writeback #(
  parameter int data_width = cpu_cfg_pkg::data_width
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   exec_valid,
  input  logic [data_width-1:0]                  exec_result,
  input  logic [cpu_isa_pkg::reg_addr_width-1:0] exec_dst,
  input  logic                                   exec_write,
  input  logic                                   req,
  output logic                                   wr_en,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] wr_addr,
  output logic [data_width-1:0]                  wr_data,
  output logic                                   ack,
  output logic [data_width-1:0]                  result_data,
  output logic [cpu_isa_pkg::reg_addr_width-1:0] result_dst
);

  ////////////////////
  // regfile write
  ////////////////////

  // write lands on the same edge that raises ack
  assign wr_en   = exec_valid & exec_write;
  assign wr_addr = exec_dst;
  assign wr_data = exec_result;

  ////////////////////
  // result and ack
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack         <= 1'b0;
      result_data <= '0;
      result_dst  <= '0;
    end else if (exec_valid) begin
      // shown even for r0 or a no-op, the regfile just ignores it
      ack         <= 1'b1;
      result_data <= exec_result;
      result_dst  <= exec_dst;
    end else if (!req) begin
      ack <= 1'b0;   // four phase, drop once req seen low
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
  --top-module tb_cpu_core -o tb_cpu_core || { echo "build failed"; exit 1; }
{ ./obj_dir/tb_cpu_core 2>&1 || echo "simulator returned an error status"; } | tee sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"

// File: tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

  import cpu_isa_pkg::*;
  import cpu_cfg_pkg::*;

  // instruction counts per test
  localparam int n_random    = 400;
  localparam int n_zero      = 20;   // r0 writes, each followed by an r0 read
  localparam int n_hold      = 20;
  localparam int n_unused    = 16;
  localparam int total_instr = 16 + 31 + n_random + 2 * n_zero + n_hold + n_unused + 16;
  localparam int cycle_limit = total_instr * 8 + 200;   // 8 cycles per handshake plus slack
  localparam int drive_delay = 10;   // ns after the rising edge

  logic                      clk;
  logic                      rst_n;
  logic                      req;
  logic [instr_width-1:0]    instr;
  logic                      ack;
  logic [data_width-1:0]     result_data;
  logic [reg_addr_width-1:0] result_dst;

  logic [data_width-1:0] model [reg_count];   // expected register contents
  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;
  int test_errors = 0;   // error_count when the current test started

  cpu_core #(.data_width(data_width), .reg_count(reg_count)) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .instr       (instr),
    .ack         (ack),
    .result_data (result_data),
    .result_dst  (result_dst)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  // low is the rs,rt byte of the instruction, immediate or shift amount
  function automatic logic [data_width-1:0] model_alu(input logic [3:0] code,
      input logic [data_width-1:0] a, input logic [data_width-1:0] b, input logic [7:0] low);
    logic [data_width-1:0] r;
    case (opcode_e'(code))
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_sll:  r = a << low[3:0];
      op_srl:  r = a >> low[3:0];   // logical
      op_lli:  r = data_width'($signed(low));
      default: r = '0;   // unused code, nothing written
    endcase
    return r;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // handshake driver
  ////////////////////

  // called at drive_delay after an edge, returns at the same phase
  task automatic run_instr(input logic [instr_width-1:0] word, input int hold);
    int lat;
    lat   = 0;
    instr = word;
    req   = 1'b1;
    while (!ack && lat < 16) begin   // ack due 4 edges after acceptance
      @(posedge clk);
      #drive_delay;
      lat++;
    end
    check_eq(lat, 4, "ack latency in edges");
    repeat (hold) begin
      @(posedge clk);
      #drive_delay;
      check_eq(32'(ack), 1, "ack held while req high");
    end
    req = 1'b0;
    @(posedge clk);
    #drive_delay;
    check_eq(32'(ack), 0, "ack fall one edge after req low");
    @(posedge clk);   // decode sees req and ack low, back to idle
    #drive_delay;
  endtask

  task automatic exec_check(input logic [3:0] code, input logic [3:0] dst,
      input logic [3:0] rs, input logic [3:0] rt, input int hold);
    logic [data_width-1:0] expected;
    expected = model_alu(code, model[rs], model[rt], {rs, rt});
    run_instr({code, dst, rs, rt}, hold);
    if (code <= op_lli) check_eq(32'(result_data), 32'(expected), "result_data");
    check_eq(32'(result_dst), 32'(dst), "result_dst");
    if (code <= op_lli && dst != 4'd0) model[dst] = expected;   // r0 stays zero
  endtask

  // or of each register with r0, into r0
  task automatic read_all();
    for (int i = 0; i < reg_count; i++) exec_check(op_or, 4'd0, 4'(i), 4'd0, 0);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished, %0d errors", num, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    logic [7:0] imm_val;
    void'($urandom(48116));
    rst_n = 1'b0;
    req   = 1'b0;
    instr = '0;
    for (int i = 0; i < reg_count; i++) model[i] = '0;
    repeat (3) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;

    check_eq(32'(ack), 0, "ack after reset");
    check_eq(32'(result_data), 0, "result_data after reset");
    check_eq(32'(result_dst), 0, "result_dst after reset");
    read_all();
    report_test(1, "reset state");

    for (int i = 1; i < reg_count; i++) begin
      imm_val = 8'($urandom);
      exec_check(op_lli, 4'(i), imm_val[7:4], imm_val[3:0], 0);
    end
    read_all();
    report_test(2, "load immediate");

    for (int n = 0; n < n_random; n++) begin   // add through srl
      exec_check(4'($urandom_range(6)), 4'($urandom), 4'($urandom), 4'($urandom), 0);
    end
    report_test(3, "random operations");

    for (int n = 0; n < n_zero; n++) begin
      exec_check(4'($urandom_range(7)), 4'd0, 4'($urandom), 4'($urandom), 0);
      exec_check(op_or, 4'd0, 4'd0, 4'd0, 0);
    end
    report_test(4, "register zero writes");

    for (int n = 0; n < n_hold; n++) begin   // req held 0 to 5 extra cycles
      exec_check(4'($urandom_range(7)), 4'($urandom), 4'($urandom), 4'($urandom),
                 int'($urandom_range(5)));
    end
    report_test(5, "handshake timing");

    for (int n = 0; n < n_unused; n++) begin
      exec_check(4'($urandom_range(15, 8)), 4'($urandom), 4'($urandom), 4'($urandom), 0);
    end
    read_all();
    report_test(6, "unused opcodes");

    $display("summary: %0d checks, %0d errors, %0d assertion failures, %0d cycles",
             check_count, error_count, UUT.u_chk.fail_count, cycle_count);
    if (error_count == 0 && UUT.u_chk.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
cpu_isa_pkg.sv
cpu_cfg_pkg.sv
instr_decode.sv
reg_file.sv
alu_execute.sv
result_writeback.sv
cpu_core.sv
cpu_core_chk.sv
tb_cpu_core.sv
